// ==== list.f ====
src/btc_pkg.sv
src/btc_in_buf.sv
src/btc_enc_ctrl.sv
src/btc_row_enc.sv
src/btc_col_lane.sv
src/btc_col_enc.sv
src/btc_work_buf.sv
src/btc_out_buf.sv
src/btc_enc_top.sv
testbench/tb_btc_enc.sv

// ==== testbench/tb_btc_enc.sv ====
// testbench for the product code encoder with random blocks in all modes,
// a reference encoder, a stream compare process and a cycle watchdog

`timescale 1ns/1ps

module tb_btc_enc;

  localparam int cBURST = 4;
  localparam int cWORDS = btc_pkg::cCOL_MAX * btc_pkg::cROW_WORDS_MAX;

  logic                 iclk;
  logic                 ireset;
  btc_pkg::btc_x_mode_t ixmode;
  btc_pkg::btc_y_mode_t iymode;
  logic                 iwrite;
  btc_pkg::btc_addr_t   iwaddr;
  btc_pkg::btc_word_t   iwdat;
  logic                 ilast;
  logic                 obusy;
  logic                 oval;
  logic                 osop;
  logic                 oeop;
  btc_pkg::btc_word_t   odat;

  integer               seed;
  // source data in the input buffer layout
  btc_pkg::btc_word_t   data_words [cWORDS];

  // expected stream with one entry per output word
  btc_pkg::btc_word_t   exp_word_q [$];
  logic                 exp_sop_q [$];
  logic                 exp_eop_q [$];

  btc_enc_top btc_enc_top_inst (
    .iclk   (iclk),
    .ireset (ireset),
    .ixmode (ixmode),
    .iymode (iymode),
    .iwrite (iwrite),
    .iwaddr (iwaddr),
    .iwdat  (iwdat),
    .ilast  (ilast),
    .obusy  (obusy),
    .oval   (oval),
    .osop   (osop),
    .oeop   (oeop),
    .odat   (odat)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // --------------------
  // checks
  // --------------------

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input btc_pkg::btc_word_t actual,
                            input btc_pkg::btc_word_t expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  // --------------------
  // reference encoder
  // --------------------

  // SPC on every row and column and the corner as parity of parities
  function automatic void ref_encode(input btc_pkg::btc_x_mode_t xmode,
                                     input btc_pkg::btc_y_mode_t ymode);
    btc_pkg::btc_word_t code [cWORDS];
    btc_pkg::btc_word_t col_par [btc_pkg::cROW_WORDS_MAX];
    int                 row_words;
    int                 code_rows;
    int                 idx;
    logic               row_par;
    row_words = btc_pkg::get_row_words(xmode);
    code_rows = btc_pkg::get_code_rows(ymode);
    for (int w = 0; w < btc_pkg::cROW_WORDS_MAX; w++) begin
      col_par[w] = '0;
    end
    for (int r = 0; r < code_rows - 1; r++) begin
      row_par = 1'b0;
      for (int w = 0; w < row_words; w++) begin
        idx       = r * btc_pkg::cROW_WORDS_MAX + w;
        code[idx] = data_words[idx];
        // source bit in the parity column is dropped
        if (w == row_words - 1) begin
          code[idx][btc_pkg::cDAT_W-1] = 1'b0;
        end
        row_par = row_par ^ (^code[idx]);
      end
      code[r * btc_pkg::cROW_WORDS_MAX + row_words - 1][btc_pkg::cDAT_W-1] = row_par;
      // column sums include the row parity bits
      for (int w = 0; w < row_words; w++) begin
        col_par[w] = col_par[w] ^ code[r * btc_pkg::cROW_WORDS_MAX + w];
      end
    end
    for (int w = 0; w < row_words; w++) begin
      code[(code_rows - 1) * btc_pkg::cROW_WORDS_MAX + w] = col_par[w];
    end
    // row-major stream order
    for (int r = 0; r < code_rows; r++) begin
      for (int w = 0; w < row_words; w++) begin
        exp_word_q.push_back(code[r * btc_pkg::cROW_WORDS_MAX + w]);
        exp_sop_q.push_back((r == 0) && (w == 0));
        exp_eop_q.push_back((r == code_rows - 1) && (w == row_words - 1));
      end
    end
  endfunction

  function automatic int block_cost(input btc_pkg::btc_x_mode_t xmode,
                                    input btc_pkg::btc_y_mode_t ymode);
    return 4 * btc_pkg::get_row_words(xmode) * btc_pkg::get_code_rows(ymode) + 100;
  endfunction

  // --------------------
  // stimulus helpers
  // --------------------

  task automatic fill_data();
    for (int i = 0; i < cWORDS; i++) begin
      data_words[i] = $random(seed);
    end
  endtask

  // flip the source bits in the parity column
  task automatic flip_parity_column(input btc_pkg::btc_x_mode_t xmode);
    int last;
    last = btc_pkg::get_row_words(xmode) - 1;
    for (int r = 0; r < btc_pkg::cCOL_MAX; r++) begin
      data_words[r * btc_pkg::cROW_WORDS_MAX + last][btc_pkg::cDAT_W-1] =
        ~data_words[r * btc_pkg::cROW_WORDS_MAX + last][btc_pkg::cDAT_W-1];
    end
  endtask

  // load the data rows once the input buffer is free and then strobe last
  task automatic send_block(input btc_pkg::btc_x_mode_t xmode,
                            input btc_pkg::btc_y_mode_t ymode);
    int row_words;
    int code_rows;
    row_words = btc_pkg::get_row_words(xmode);
    code_rows = btc_pkg::get_code_rows(ymode);
    @(posedge iclk);
    #2;
    while (obusy) begin
      @(posedge iclk);
      #2;
    end
    ixmode = xmode;
    iymode = ymode;
    for (int r = 0; r < code_rows - 1; r++) begin
      for (int w = 0; w < row_words; w++) begin
        iwrite = 1'b1;
        iwaddr = btc_pkg::btc_addr_t'(r * btc_pkg::cROW_WORDS_MAX + w);
        iwdat  = data_words[r * btc_pkg::cROW_WORDS_MAX + w];
        @(posedge iclk);
        #2;
      end
    end
    iwrite = 1'b0;
    ilast  = 1'b1;
    @(posedge iclk);
    #2;
    ilast = 1'b0;
    check_flag("obusy", obusy, 1'b1);
    ref_encode(xmode, ymode);
  endtask

  task automatic wait_drain();
    while (exp_word_q.size() != 0) begin
      @(posedge iclk);
    end
  endtask

  // --------------------
  // compare process
  // --------------------

  initial begin : compare
    btc_pkg::btc_word_t exp_word;
    logic               exp_sop;
    logic               exp_eop;
    forever begin
      @(negedge iclk);
      if (!ireset) begin
        if (oval) begin
          if (exp_word_q.size() == 0) begin
            $display("output word seen with no block pending");
            abort_run();
          end
          else begin
            exp_word = exp_word_q.pop_front();
            exp_sop  = exp_sop_q.pop_front();
            exp_eop  = exp_eop_q.pop_front();
            check_word("odat", odat, exp_word);
            check_flag("osop", osop, exp_sop);
            check_flag("oeop", oeop, exp_eop);
          end
        end
        else begin
          // strobes only ride with valid words
          check_flag("osop", osop, 1'b0);
          check_flag("oeop", oeop, 1'b0);
        end
      end
    end
  end

  // watchdog sized from the block list below
  initial begin : watchdog
    int limit;
    int cycles;
    limit = 0;
    for (int x = 0; x < 3; x++) begin
      for (int y = 0; y < 3; y++) begin
        limit += block_cost(btc_pkg::btc_x_mode_t'(x), btc_pkg::btc_y_mode_t'(y));
      end
    end
    // parity junk test sends its block twice
    limit += 2 * block_cost(btc_pkg::cX32, btc_pkg::cY16);
    limit += cBURST * block_cost(btc_pkg::cX16, btc_pkg::cY8);
    cycles = 0;
    forever begin
      @(posedge iclk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout after %0d cycles, blocks did not complete", cycles);
        abort_run();
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin : stimulus
    ireset = 1'b1;
    ixmode = btc_pkg::cX8;
    iymode = btc_pkg::cY4;
    iwrite = 1'b0;
    iwaddr = '0;
    iwdat  = '0;
    ilast  = 1'b0;
    seed   = 32'h3b6d;
    repeat (3) @(posedge iclk);
    #2;
    ireset = 1'b0;

    // quiet outputs before any block
    repeat (10) begin
      @(negedge iclk);
      check_flag("oval", oval, 1'b0);
      check_flag("osop", osop, 1'b0);
      check_flag("oeop", oeop, 1'b0);
      check_flag("obusy", obusy, 1'b0);
    end

    // one block per mode pair and drained before the modes change
    for (int x = 0; x < 3; x++) begin
      for (int y = 0; y < 3; y++) begin
        fill_data();
        send_block(btc_pkg::btc_x_mode_t'(x), btc_pkg::btc_y_mode_t'(y));
        wait_drain();
      end
    end

    // same data twice with the parity column junk inverted the second time
    fill_data();
    send_block(btc_pkg::cX32, btc_pkg::cY16);
    flip_parity_column(btc_pkg::cX32);
    send_block(btc_pkg::cX32, btc_pkg::cY16);
    wait_drain();

    // each back to back load starts as soon as obusy falls
    for (int b = 0; b < cBURST; b++) begin
      fill_data();
      send_block(btc_pkg::cX16, btc_pkg::cY8);
    end
    wait_drain();

    repeat (10) @(posedge iclk);
    if (exp_word_q.size() != 0 || obusy) begin
      $display("blocks still pending at the end of the run");
      abort_run();
    end
    else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== src/btc_enc_top.sv ====
// product code encoder top: input buffer, controller, row and column
// encoders, work matrix and output stream buffer

`timescale 1ns/1ps

module btc_enc_top (
  input  logic                 iclk,
  input  logic                 ireset,
  input  btc_pkg::btc_x_mode_t ixmode,
  input  btc_pkg::btc_y_mode_t iymode,
  input  logic                 iwrite,
  input  btc_pkg::btc_addr_t   iwaddr,
  input  btc_pkg::btc_word_t   iwdat,
  input  logic                 ilast,
  output logic                 obusy,
  output logic                 oval,
  output logic                 osop,
  output logic                 oeop,
  output btc_pkg::btc_word_t   odat
);

  // shared read address and data
  btc_pkg::btc_addr_t buf_addr;
  btc_pkg::btc_word_t in_rdat;
  btc_pkg::btc_word_t work_rdat;
  btc_pkg::btc_word_t rd_dat;
  logic               row_mode;

  logic               rempty;
  logic               wbuf_empty;
  logic               wbuf_busy;
  logic               wb_write;
  logic               wb_full;

  // row encoder
  logic               row_val;
  logic               row_sop;
  logic               row_eop;
  logic               row_busy;
  logic               row_write;
  btc_pkg::btc_addr_t row_waddr;
  btc_pkg::btc_word_t row_wdat;

  // column encoder
  logic               col_val;
  logic               col_sop;
  logic               col_eop;
  logic               col_eof;
  logic               col_busy;
  logic               col_write;
  btc_pkg::btc_addr_t col_waddr;
  btc_pkg::btc_word_t col_wdat;

  // input buffer in the row pass, work matrix after it
  assign rd_dat = row_mode ? in_rdat : work_rdat;

  btc_in_buf btc_in_buf_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iwrite  (iwrite),
    .iwaddr  (iwaddr),
    .iwdat   (iwdat),
    .ilast   (ilast),
    .irempty (rempty),
    .iraddr  (buf_addr),
    .ordat   (in_rdat),
    .ofull   (obusy)
  );

  btc_enc_ctrl btc_enc_ctrl_inst (
    .iclk          (iclk),
    .ireset        (ireset),
    .ixmode        (ixmode),
    .iymode        (iymode),
    .irbuf_full    (obusy),
    .iwbuf_empty   (wbuf_empty),
    .irow_enc_busy (row_busy),
    .icol_enc_busy (col_busy),
    .iwrite_busy   (wbuf_busy),
    .orempty       (rempty),
    .obuf_addr     (buf_addr),
    .orow_mode     (row_mode),
    .orow_enc_sop  (row_sop),
    .orow_enc_eop  (row_eop),
    .orow_enc_val  (row_val),
    .ocol_enc_sop  (col_sop),
    .ocol_enc_eop  (col_eop),
    .ocol_enc_eof  (col_eof),
    .ocol_enc_val  (col_val),
    .owrite        (wb_write),
    .owfull        (wb_full)
  );

  btc_row_enc btc_row_enc_inst (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (row_val),
    .isop   (row_sop),
    .ieop   (row_eop),
    .iaddr  (buf_addr),
    .idat   (rd_dat),
    .owrite (row_write),
    .owaddr (row_waddr),
    .owdat  (row_wdat),
    .obusy  (row_busy)
  );

  btc_col_enc btc_col_enc_inst (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (col_val),
    .isop   (col_sop),
    .ieop   (col_eop),
    .ieof   (col_eof),
    .iaddr  (buf_addr),
    .idat   (rd_dat),
    .owrite (col_write),
    .owaddr (col_waddr),
    .owdat  (col_wdat),
    .obusy  (col_busy)
  );

  btc_work_buf btc_work_buf_inst (
    .iclk       (iclk),
    .irow_write (row_write),
    .irow_waddr (row_waddr),
    .irow_wdat  (row_wdat),
    .icol_write (col_write),
    .icol_waddr (col_waddr),
    .icol_wdat  (col_wdat),
    .iraddr     (buf_addr),
    .ordat      (work_rdat)
  );

  btc_out_buf btc_out_buf_inst (
    .iclk   (iclk),
    .ireset (ireset),
    .ixmode (ixmode),
    .iymode (iymode),
    .iwrite (wb_write),
    .iwfull (wb_full),
    .iwaddr (buf_addr),
    .iwdat  (rd_dat),
    .owbusy (wbuf_busy),
    .oempty (wbuf_empty),
    .oval   (oval),
    .osop   (osop),
    .oeop   (oeop),
    .odat   (odat)
  );

endmodule

// ==== src/btc_out_buf.sv ====
// output memory, filled by write-back and streamed out
// row-major with valid, start and end strobes

`timescale 1ns/1ps

module btc_out_buf (
  input  logic                 iclk,
  input  logic                 ireset,
  input  btc_pkg::btc_x_mode_t ixmode,
  input  btc_pkg::btc_y_mode_t iymode,
  input  logic                 iwrite,
  input  logic                 iwfull,
  input  btc_pkg::btc_addr_t   iwaddr,
  input  btc_pkg::btc_word_t   iwdat,
  output logic                 owbusy,
  output logic                 oempty,
  output logic                 oval,
  output logic                 osop,
  output logic                 oeop,
  output btc_pkg::btc_word_t   odat
);

  btc_pkg::btc_word_t mem [btc_pkg::cCOL_MAX * btc_pkg::cROW_WORDS_MAX];

  logic               wr_r;
  logic               full_r;
  btc_pkg::btc_addr_t waddr_r;

  // stream read side
  logic               rd_active;
  btc_pkg::btc_row_t  rd_row;
  btc_pkg::btc_wcnt_t rd_word;
  btc_pkg::btc_row_t  last_row;
  btc_pkg::btc_wcnt_t last_word;
  logic               rd_first;
  logic               rd_last;

  // ------------------
  // write stage
  // ------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_r   <= 1'b0;
      full_r <= 1'b0;
    end
    else begin
      wr_r   <= iwrite;
      full_r <= iwfull;
    end
  end

  // data comes one cycle after its address
  always_ff @(posedge iclk) begin
    waddr_r <= iwaddr;
    if (wr_r) begin
      mem[waddr_r] <= iwdat;
    end
    odat <= mem[{rd_row, rd_word}];
  end

  // ------------------
  // stream
  // ------------------

  assign rd_first = (rd_row == '0) & (rd_word == '0);
  assign rd_last  = (rd_row == last_row) & (rd_word == last_word);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_active <= 1'b0;
      rd_row    <= '0;
      rd_word   <= '0;
      last_row  <= '0;
      last_word <= '0;
      oval      <= 1'b0;
      osop      <= 1'b0;
      oeop      <= 1'b0;
    end
    else begin
      if (full_r) begin
        rd_active <= 1'b1;
        rd_row    <= '0;
        rd_word   <= '0;
        // block size kept for the whole stream
        last_row  <= btc_pkg::btc_row_t'(btc_pkg::get_code_rows(iymode) - 1);
        last_word <= btc_pkg::btc_wcnt_t'(btc_pkg::get_row_words(ixmode) - 1);
      end
      else if (rd_active) begin
        if (rd_word == last_word) begin
          rd_word <= '0;
          rd_row  <= rd_row + 1'b1;
        end
        else begin
          rd_word <= rd_word + 1'b1;
        end
        if (rd_last) begin
          rd_active <= 1'b0;
        end
      end
      // strobes ride with the read data
      oval <= rd_active;
      osop <= rd_active & rd_first;
      oeop <= rd_active & rd_last;
    end
  end

  assign owbusy = wr_r;
  // busy from the registered full strobe until the last word leaves
  assign oempty = ~(full_r | rd_active | oval);

endmodule

// ==== src/btc_work_buf.sv ====
// work matrix between the encoder passes
// row encoder fills it, column encoder adds the parity row

`timescale 1ns/1ps

module btc_work_buf (
  input  logic               iclk,
  input  logic               irow_write,
  input  btc_pkg::btc_addr_t irow_waddr,
  input  btc_pkg::btc_word_t irow_wdat,
  input  logic               icol_write,
  input  btc_pkg::btc_addr_t icol_waddr,
  input  btc_pkg::btc_word_t icol_wdat,
  input  btc_pkg::btc_addr_t iraddr,
  output btc_pkg::btc_word_t ordat
);

  btc_pkg::btc_word_t mem [btc_pkg::cCOL_MAX * btc_pkg::cROW_WORDS_MAX];

  // one write port, the phases keep the writers apart
  always_ff @(posedge iclk) begin
    if (irow_write) begin
      mem[irow_waddr] <= irow_wdat;
    end
    else if (icol_write) begin
      mem[icol_waddr] <= icol_wdat;
    end
  end

  // registered read for column pass and write-back
  always_ff @(posedge iclk) begin
    ordat <= mem[iraddr];
  end

endmodule

// ==== src/btc_col_enc.sv ====
// column SPC encoder: eight bit lanes over one word column
// writes the parity row word after the parity row address

`timescale 1ns/1ps

module btc_col_enc (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ival,
  input  logic               isop,
  input  logic               ieop,
  input  logic               ieof,
  input  btc_pkg::btc_addr_t iaddr,
  input  btc_pkg::btc_word_t idat,
  output logic               owrite,
  output btc_pkg::btc_addr_t owaddr,
  output btc_pkg::btc_word_t owdat,
  output logic               obusy
);

  logic               val_r;
  logic               sop_r;
  logic               eop_r;
  logic               eof_r;
  logic               lane_val;
  btc_pkg::btc_addr_t addr_r;
  btc_pkg::btc_word_t parity;

  // strobes meet the work buffer read data
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r  <= 1'b0;
      sop_r  <= 1'b0;
      eop_r  <= 1'b0;
      eof_r  <= 1'b0;
      owrite <= 1'b0;
    end
    else begin
      val_r  <= ival;
      sop_r  <= isop;
      eop_r  <= ieop;
      eof_r  <= ieof;
      owrite <= val_r & eof_r;
    end
  end

  // parity row is not part of its own column sum
  assign lane_val = val_r & ~eof_r;

  genvar i;
  generate
    for (i = 0; i < btc_pkg::cDAT_W; i++) begin : g_lane
      btc_col_lane btc_col_lane_inst (
        .iclk    (iclk),
        .ireset  (ireset),
        .ival    (lane_val),
        .isop    (sop_r),
        .ieop    (eop_r),
        .ibit    (idat[i]),
        .oparity (parity[i])
      );
    end
  endgenerate

  // lanes are final when the parity row data shows up
  always_ff @(posedge iclk) begin
    addr_r <= iaddr;
    owaddr <= addr_r;
    owdat  <= parity;
  end

  assign obusy = val_r | owrite;

endmodule

// ==== src/btc_col_lane.sv ====
// one bit lane of the column encoder
// accumulates the parity of its column over the data rows

`timescale 1ns/1ps

module btc_col_lane (
  input  logic iclk,
  input  logic ireset,
  input  logic ival,
  input  logic isop,
  input  logic ieop,
  input  logic ibit,
  output logic oparity
);

  logic active;

  // open on sop, close after eop
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active <= 1'b0;
    end
    else if (ival && (isop || active)) begin
      active <= ~ieop;
    end
  end

  // result held until the next sop
  always_ff @(posedge iclk) begin
    if (ival && isop) begin
      oparity <= ibit;
    end
    else if (ival && active) begin
      oparity <= oparity ^ ibit;
    end
  end

endmodule

// ==== src/btc_row_enc.sv ====
// row SPC encoder: passes row words through to the work buffer
// and puts the row parity into the top bit of the last word

`timescale 1ns/1ps

module btc_row_enc (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               ival,
  input  logic               isop,
  input  logic               ieop,
  input  btc_pkg::btc_addr_t iaddr,
  input  btc_pkg::btc_word_t idat,
  output logic               owrite,
  output btc_pkg::btc_addr_t owaddr,
  output btc_pkg::btc_word_t owdat,
  output logic               obusy
);

  logic               val_r;
  logic               sop_r;
  logic               eop_r;
  btc_pkg::btc_addr_t addr_r;
  logic               acc;
  logic               acc_in;
  logic               par;

  // align with the buffer read latency
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r  <= 1'b0;
      sop_r  <= 1'b0;
      eop_r  <= 1'b0;
      owrite <= 1'b0;
    end
    else begin
      val_r  <= ival;
      sop_r  <= isop;
      eop_r  <= ieop;
      owrite <= val_r;
    end
  end

  // running parity restarts at the first word of a row
  assign acc_in = sop_r ? 1'b0 : acc;
  // top bit of the last word is the parity slot itself
  assign par    = acc_in ^ (^idat[btc_pkg::cDAT_W-2:0]);

  always_ff @(posedge iclk) begin
    addr_r <= iaddr;
    if (val_r) begin
      acc <= acc_in ^ (^idat);
    end
    owaddr <= addr_r;
    owdat  <= eop_r ? {par, idat[btc_pkg::cDAT_W-2:0]} : idat;
  end

  assign obusy = val_r | owrite;

endmodule

// ==== src/btc_enc_ctrl.sv ====
// encoder sequencer: row pass, column pass, then write-back
// drives the shared buffer address and the encoder strobes

`timescale 1ns/1ps

module btc_enc_ctrl (
  input  logic                  iclk,
  input  logic                  ireset,
  input  btc_pkg::btc_x_mode_t  ixmode,
  input  btc_pkg::btc_y_mode_t  iymode,
  input  logic                  irbuf_full,
  input  logic                  iwbuf_empty,
  input  logic                  irow_enc_busy,
  input  logic                  icol_enc_busy,
  input  logic                  iwrite_busy,
  output logic                  orempty,
  output btc_pkg::btc_addr_t    obuf_addr,
  output logic                  orow_mode,
  output logic                  orow_enc_sop,
  output logic                  orow_enc_eop,
  output logic                  orow_enc_val,
  output logic                  ocol_enc_sop,
  output logic                  ocol_enc_eop,
  output logic                  ocol_enc_eof,
  output logic                  ocol_enc_val,
  output logic                  owrite,
  output logic                  owfull
);

  typedef enum logic [2:0] {
    cRESET,
    cWAIT,
    cDO_ROW,
    cWAIT_ROW,
    cDO_COL,
    cWAIT_COL,
    cDO_WRITE,
    cDONE
  } state_t;

  state_t state;

  // index counters, flags are registered lookahead
  btc_pkg::btc_wcnt_t word;
  btc_pkg::btc_wcnt_t word_nxt;
  btc_pkg::btc_wcnt_t word_last;
  logic               word_zero;
  logic               word_done;

  btc_pkg::btc_row_t  row;
  btc_pkg::btc_row_t  row_nxt;
  btc_pkg::btc_row_t  row_data_last;
  btc_pkg::btc_row_t  row_code_last;
  logic               row_zero;
  logic               row_data_done;
  logic               row_code_done;

  logic               word_step;
  logic               row_step;
  logic               cnt_clear;
  logic               row_pass_done;
  logic               code_pass_done;

  // ------------------
  // sizes from modes
  // ------------------

  assign word_last     = btc_pkg::btc_wcnt_t'(btc_pkg::get_row_words(ixmode) - 1);
  // parity row is the last code row
  assign row_code_last = btc_pkg::btc_row_t'(btc_pkg::get_code_rows(iymode) - 1);
  assign row_data_last = btc_pkg::btc_row_t'(btc_pkg::get_code_rows(iymode) - 2);

  // row pass covers data rows only
  assign row_pass_done  = word_done & row_data_done;
  // column pass and write-back cover all code rows
  assign code_pass_done = word_done & row_code_done;

  // ------------------
  // fsm
  // ------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cRESET;
    end
    else begin
      case (state)
        cRESET    : state <= cWAIT;
        cWAIT     : if (irbuf_full && iwbuf_empty) state <= cDO_ROW;
        cDO_ROW   : if (row_pass_done) state <= cWAIT_ROW;
        // let the row encoder drain its last word
        cWAIT_ROW : if (!irow_enc_busy) state <= cDO_COL;
        cDO_COL   : if (code_pass_done) state <= cWAIT_COL;
        // parity row write still in flight
        cWAIT_COL : if (!icol_enc_busy) state <= cDO_WRITE;
        cDO_WRITE : if (code_pass_done) state <= cDONE;
        cDONE     : if (!iwrite_busy) state <= cWAIT;
        default   : state <= cWAIT;
      endcase
    end
  end

  // ------------------
  // counters
  // ------------------

  // row and write passes: word inner, column pass: row inner
  always_comb begin
    word_step = 1'b0;
    row_step  = 1'b0;
    case (state)
      cDO_ROW, cDO_WRITE : begin
        word_step = 1'b1;
        row_step  = word_done;
      end
      cDO_COL : begin
        word_step = row_code_done;
        row_step  = 1'b1;
      end
      default : begin
      end
    endcase
  end

  assign cnt_clear = (state == cRESET) | (state == cWAIT) |
                     (state == cWAIT_ROW) | (state == cWAIT_COL);

  assign word_nxt = word_done ? '0 : word + 1'b1;
  assign row_nxt  = row_code_done ? '0 : row + 1'b1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      word          <= '0;
      word_zero     <= 1'b0;
      word_done     <= 1'b0;
      row           <= '0;
      row_zero      <= 1'b0;
      row_data_done <= 1'b0;
      row_code_done <= 1'b0;
    end
    else if (cnt_clear) begin
      word          <= '0;
      word_zero     <= 1'b1;
      // single word rows end on every word
      word_done     <= (word_last == '0);
      row           <= '0;
      row_zero      <= 1'b1;
      row_data_done <= 1'b0;
      row_code_done <= 1'b0;
    end
    else begin
      if (word_step) begin
        word      <= word_nxt;
        word_zero <= word_done;
        word_done <= (word_nxt == word_last);
      end
      if (row_step) begin
        row           <= row_nxt;
        row_zero      <= row_code_done;
        row_data_done <= (row_nxt == row_data_last);
        row_code_done <= (row_nxt == row_code_last);
      end
    end
  end

  // ------------------
  // outputs
  // ------------------

  assign obuf_addr = {row, word};

  // input buffer data still arrives in the row wait cycle
  assign orow_mode = (state == cDO_ROW) | (state == cWAIT_ROW);

  // encoders register these to meet the read data
  assign orow_enc_val = (state == cDO_ROW);
  assign orow_enc_sop = orow_enc_val & word_zero;
  assign orow_enc_eop = orow_enc_val & word_done;

  assign ocol_enc_val = (state == cDO_COL);
  assign ocol_enc_sop = ocol_enc_val & row_zero;
  assign ocol_enc_eop = ocol_enc_val & row_data_done;
  assign ocol_enc_eof = ocol_enc_val & row_code_done;

  assign owrite  = (state == cDO_WRITE);
  assign owfull  = owrite & code_pass_done;
  // input buffer is free once its last word went out
  assign orempty = owfull;

endmodule

// ==== src/btc_in_buf.sv ====
// input data memory, written by the source and read by the row encoder
// full flag marks a loaded block until write-back frees it

`timescale 1ns/1ps

module btc_in_buf (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iwrite,
  input  btc_pkg::btc_addr_t iwaddr,
  input  btc_pkg::btc_word_t iwdat,
  input  logic              ilast,
  input  logic              irempty,
  input  btc_pkg::btc_addr_t iraddr,
  output btc_pkg::btc_word_t ordat,
  output logic              ofull
);

  // one slot per row and word
  btc_pkg::btc_word_t mem [btc_pkg::cCOL_MAX * btc_pkg::cROW_WORDS_MAX];

  // source side write, registered read for the controller
  always_ff @(posedge iclk) begin
    if (iwrite) begin
      mem[iwaddr] <= iwdat;
    end
    ordat <= mem[iraddr];
  end

  // set on last strobe, cleared on the final write-back cycle
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ofull <= 1'b0;
    end
    else if (ilast) begin
      ofull <= 1'b1;
    end
    else if (irempty) begin
      ofull <= 1'b0;
    end
  end

endmodule

// ==== src/btc_pkg.sv ====
// shared sizes, word types, code modes and mode-to-size helpers
// for the product code encoder, referenced by scoped names

package btc_pkg;

  // ------------------
  // sizes
  // ------------------

  // bits per buffer word
  localparam int cDAT_W         = 8;
  // a 32-bit row spans 4 words
  localparam int cROW_WORDS_MAX = 4;
  // longest column code
  localparam int cCOL_MAX       = 16;
  // row index above word index
  localparam int cADDR_W        = 6;

  // ------------------
  // types
  // ------------------

  // bit j of word w is matrix column 8w+j
  typedef logic [cDAT_W-1:0]  btc_word_t;
  typedef logic [cADDR_W-1:0] btc_addr_t;
  typedef logic [3:0]         btc_row_t;
  typedef logic [1:0]         btc_wcnt_t;

  // row code length in bits
  typedef enum logic [1:0] {
    cX8,
    cX16,
    cX32
  } btc_x_mode_t;

  // column code length in rows
  typedef enum logic [1:0] {
    cY4,
    cY8,
    cY16
  } btc_y_mode_t;

  // ------------------
  // mode decoding
  // ------------------

  // buffer words in one row
  function automatic int get_row_words(btc_x_mode_t xmode);
    case (xmode)
      cX8     : return 1;
      cX16    : return 2;
      default : return cROW_WORDS_MAX;
    endcase
  endfunction

  // code rows, last one is the column parity row
  function automatic int get_code_rows(btc_y_mode_t ymode);
    case (ymode)
      cY4     : return 4;
      cY8     : return 8;
      default : return cCOL_MAX;
    endcase
  endfunction

endpackage
